// File: nes_loader.f
+incdir+.
nes_loader_pkg.sv
download_dispatch.sv
ines_header_decoder.sv
rom_loader_fsm.sv
cheat_code_assembler.sv
palette_loader.sv
nes_loader_top.sv
tb_nes_loader.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the NES loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module tb_nes_loader \
	-f nes_loader.f -o sim_nes_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_nes_loader 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: tb_nes_loader.sv
// Testbench for the NES cartridge download front end
// Directed ROM, cheat, palette and kind isolation tests
`timescale 1ns/1ns
`include "nes_loader_consts.svh"

module tb_nes_loader;

	logic                           clk;
	logic                           reset_nes;
	logic                           download;
	logic                           invert_mirroring;
	logic [7:0]                     download_index;
	nes_loader_pkg::host_byte_t     host_in;
	nes_loader_pkg::mem_write_t     mem_out;
	nes_loader_pkg::mapper_flags_t  mapper_flags;
	logic                           loader_busy;
	logic                           loader_done;
	logic                           loader_error;
	logic                           cheat_valid;
	nes_loader_pkg::cheat_code_t    cheat_code;
	nes_loader_pkg::palette_write_t palette_out;

	logic [7:0]   header [0:15];
	logic [29:0]  mem_q [$]; // {addr, data}
	logic [20:0]  pal_q [$]; // {index, color}
	logic [29:0]  mem_exp;
	logic [20:0]  pal_exp;
	logic [127:0] cheat_seen;
	int           cheat_count = 0;
	int           pal_count = 0;

	nes_loader_top dut (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.download         (download),
		.invert_mirroring (invert_mirroring),
		.download_index   (download_index),
		.host_in          (host_in),
		.mem_out          (mem_out),
		.mapper_flags     (mapper_flags),
		.loader_busy      (loader_busy),
		.loader_done      (loader_done),
		.loader_error     (loader_error),
		.cheat_valid      (cheat_valid),
		.cheat_code       (cheat_code),
		.palette_out      (palette_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// Reporting

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] expected);
		if (got !== expected)
			fail_run($sformatf("mismatch at %0t ns: %s got %0h expected %0h",
				$time, name, got, expected));
	endtask

	//////////////////////////////
	// Monitors sampled mid-cycle

	always @(negedge clk) begin
		if (!reset_nes && mem_out.write) begin
			if (mem_q.size() == 0) begin
				fail_run($sformatf("unexpected memory write to address %0h at %0t ns",
					mem_out.addr, $time));
			end else begin
				mem_exp = mem_q.pop_front();
				check_value("mem_out.addr", 128'(mem_out.addr), 128'(mem_exp[29:8]));
				check_value("mem_out.data", 128'(mem_out.data), 128'(mem_exp[7:0]));
			end
		end
	end

	always @(negedge clk) begin
		if (!reset_nes && palette_out.write) begin
			if (pal_q.size() == 0) begin
				fail_run($sformatf("unexpected palette write at %0t ns", $time));
			end else begin
				pal_exp = pal_q.pop_front();
				check_value("palette_out", 128'({palette_out.index, palette_out.color}),
					128'(pal_exp));
				pal_count = pal_count + 1;
			end
		end
	end

	always @(negedge clk) begin
		if (!reset_nes && cheat_valid) begin
			cheat_count = cheat_count + 1;
			cheat_seen  = cheat_code;
		end
	end

	//////////////////////////////
	// Drivers and waits

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	// One strobe and one idle cycle
	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		host_in.strobe = 1'b1;
		host_in.addr   = addr;
		host_in.data   = data;
		next_cycle();
		host_in.strobe = 1'b0;
		next_cycle();
	endtask

	task automatic start_download(input logic [7:0] index);
		download_index = index;
		download       = 1'b1;
		next_cycle(); // Restart edge
	endtask

	task automatic end_download();
		download = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	task automatic wait_for_done();
		int n;
		n = 0;
		while (loader_done !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > 50)
				fail_run("timed out waiting for loader_done to rise");
		end
		next_cycle();
	endtask

	task automatic wait_for_cheat(input int target);
		int n;
		n = 0;
		while (cheat_count < target) begin
			@(negedge clk);
			n++;
			if (n > 50)
				fail_run("timed out waiting for a cheat_valid pulse");
		end
		next_cycle();
	endtask

	task automatic wait_for_palette_drain();
		int n;
		n = 0;
		while (pal_q.size() != 0) begin
			@(negedge clk);
			n++;
			if (n > 50)
				fail_run("timed out waiting for the expected palette writes");
		end
		next_cycle();
	endtask

	//////////////////////////////
	// Expected values

	// Ceiling log2 of the page count, at most 7
	function automatic logic [2:0] size_for_pages(input logic [7:0] pages);
		int c;
		c = 0;
		while (c < 7 && (1 << c) < int'(pages))
			c++;
		return 3'(c);
	endfunction

	function automatic logic [31:0] expected_flags(input logic inv);
		logic       nes20;
		logic       dirty;
		logic [3:0] mapper_hi;
		nes20 = (header[7][3:2] == 2'b10);
		dirty = !nes20 && ((header[9][7:1] != 7'd0) || (header[10] != 8'd0) ||
			(header[11] != 8'd0) || (header[12] != 8'd0) ||
			(header[13] != 8'd0) || (header[14] != 8'd0) || (header[15] != 8'd0));
		mapper_hi = dirty ? 4'h0 : header[7][7:4];
		// Piano and PRG RAM shift stay clear while bytes 10 and 15 are zero
		return {1'b0, 1'b0, 4'h0, header[6][1], (nes20 ? header[8] : 8'h00),
			header[6][3], (header[5] == 8'd0), header[6][0] ^ inv,
			size_for_pages(header[5]), size_for_pages(header[4]),
			mapper_hi, header[6][7:4]};
	endfunction

	task automatic set_header(input logic [7:0] prg, input logic [7:0] chr,
		input logic [7:0] f6, input logic [7:0] f7);
		int i;
		for (i = 0; i < 16; i++)
			header[i] = 8'h00;
		header[0] = `INES_MAGIC0;
		header[1] = `INES_MAGIC1;
		header[2] = `INES_MAGIC2;
		header[3] = `INES_MAGIC3;
		header[4] = prg;
		header[5] = chr;
		header[6] = f6;
		header[7] = f7;
	endtask

	// Header bytes land at 0..15 and random bodies follow
	task automatic load_rom(input bit accepted);
		int         i;
		int         prg_bytes;
		int         chr_bytes;
		logic [7:0] d;
		prg_bytes = accepted ? int'(header[4]) * `PRG_PAGE_BYTES : 0;
		chr_bytes = accepted ? int'(header[5]) * `CHR_PAGE_BYTES : 0;
		start_download(8'h40);
		for (i = 0; i < 16; i++) begin
			mem_q.push_back({22'(i), header[i]});
			send_byte(25'(i), header[i]);
		end
		if (accepted)
			check_value("loader_busy", 128'(loader_busy), 128'(1'b1));
		for (i = 0; i < prg_bytes; i++) begin
			d = 8'($urandom());
			mem_q.push_back({`PRG_BASE_ADDR + 22'(i), d});
			send_byte(25'(16 + i), d);
		end
		for (i = 0; i < chr_bytes; i++) begin
			d = 8'($urandom());
			mem_q.push_back({`CHR_BASE_ADDR + 22'(i), d});
			send_byte(25'(16 + prg_bytes + i), d);
		end
		if (!accepted) begin
			for (i = 0; i < 4; i++)
				send_byte(25'(16 + i), 8'($urandom())); // Must not be written
		end
		wait_for_done();
		check_value("loader_done", 128'(loader_done), 128'(1'b1));
		check_value("loader_error", 128'(loader_error), 128'(!accepted));
		check_value("loader_busy", 128'(loader_busy), 128'(1'b0));
		check_value("pending memory writes", 128'(mem_q.size()), 128'(0));
		end_download();
	endtask

	//////////////////////////////
	// Tests

	task automatic test_rom_load();
		invert_mirroring = 1'b0;
		set_header(8'd1, 8'd1, 8'h00, 8'h00);
		load_rom(1'b1);
	endtask

	task automatic test_mapper_flags();
		invert_mirroring = 1'b1;
		set_header(8'd3, 8'd0, 8'h40, 8'h08); // Mapper 4, NES 2.0
		load_rom(1'b1);
		check_value("mapper_flags", 128'(mapper_flags), 128'(expected_flags(1'b1)));
		check_value("mapper_flags.mapper", 128'(mapper_flags.mapper), 128'(8'd4));
		set_header(8'd0, 8'd0, 8'h11, 8'h40);
		header[12] = 8'h55; // Dirty tail
		load_rom(1'b1);
		check_value("mapper_flags", 128'(mapper_flags), 128'(expected_flags(1'b1)));
		check_value("mapper_flags.mapper", 128'(mapper_flags.mapper), 128'(8'd1));
	endtask

	task automatic test_rejected();
		set_header(8'd1, 8'd1, 8'h00, 8'h00);
		header[1] = 8'h00;
		load_rom(1'b0);
		set_header(8'd1, 8'd1, 8'h04, 8'h00); // Trainer present
		load_rom(1'b0);
	endtask

	task automatic test_cheat();
		int          i;
		int          count0;
		logic [7:0]  b;
		logic [31:0] words [0:3];
		count0 = cheat_count;
		start_download(8'hFF);
		for (i = 0; i < 16; i++) begin
			b = 8'($urandom());
			words[i / 4][(i % 4) * 8 +: 8] = b;
			send_byte(25'(i), b);
		end
		wait_for_cheat(count0 + 1);
		next_cycle();
		next_cycle();
		check_value("cheat_valid pulses", 128'(cheat_count - count0), 128'(1));
		check_value("cheat_code", cheat_seen, {words[0], words[1], words[2], words[3]});
		end_download();
	endtask

	task automatic test_palette();
		int         t;
		int         c;
		int         count0;
		logic [7:0] rgb [0:2];
		count0 = pal_count;
		start_download(8'h03);
		for (t = 0; t < 6; t++) begin
			for (c = 0; c < 3; c++) begin
				rgb[c] = 8'($urandom());
				send_byte(25'(t * 3 + c), rgb[c]);
			end
			pal_q.push_back({6'(t), rgb[2][7:3], rgb[1][7:3], rgb[0][7:3]});
		end
		wait_for_palette_drain();
		for (c = 0; c < 3; c++)
			send_byte(25'(`PALETTE_FILE_BYTES + c), 8'($urandom()));
		next_cycle();
		next_cycle();
		check_value("palette writes", 128'(pal_count - count0), 128'(6));
		end_download();
	endtask

	// A full record length so that a cheat or palette route would show
	task automatic test_isolation();
		int   i;
		int   cheats;
		int   pals;
		logic done_before;
		logic error_before;
		cheats       = cheat_count;
		pals         = pal_count;
		done_before  = loader_done;
		error_before = loader_error;
		start_download(8'h02); // Unknown kind
		for (i = 0; i < `CHEAT_RECORD_BYTES; i++)
			send_byte(25'(i), 8'($urandom()));
		next_cycle();
		next_cycle();
		check_value("loader_done", 128'(loader_done), 128'(done_before));
		check_value("loader_error", 128'(loader_error), 128'(error_before));
		check_value("cheat_valid pulses", 128'(cheat_count), 128'(cheats));
		check_value("palette writes", 128'(pal_count), 128'(pals));
		end_download();
	endtask

	initial begin
		void'($urandom(32'hcefcb7e3));
		reset_nes        = 1'b1;
		download         = 1'b0;
		invert_mirroring = 1'b0;
		download_index   = 8'h00;
		host_in          = '0;
		repeat (4) @(posedge clk);
		#10;
		reset_nes = 1'b0;

		check_value("loader_busy", 128'(loader_busy), 128'(1'b0));
		check_value("loader_done", 128'(loader_done), 128'(1'b0));
		check_value("loader_error", 128'(loader_error), 128'(1'b0));
		check_value("mem_out.write", 128'(mem_out.write), 128'(1'b0));
		check_value("cheat_valid", 128'(cheat_valid), 128'(1'b0));
		check_value("palette_out.write", 128'(palette_out.write), 128'(1'b0));

		test_rom_load();
		test_mapper_flags();
		test_rejected();
		test_cheat();
		test_palette();
		test_isolation();

		if (mem_q.size() == 0 && pal_q.size() == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			fail_run("expected writes never appeared");
		end
	end

endmodule

// File: nes_loader_top.sv
// NES cartridge download front end
// Dispatch, ROM loader with header decode, cheat and palette loaders
`timescale 1ns/1ns

module nes_loader_top (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           download,
	input  logic                           invert_mirroring,
	input  logic [7:0]                     download_index,
	input  nes_loader_pkg::host_byte_t     host_in,
	output nes_loader_pkg::mem_write_t     mem_out,
	output nes_loader_pkg::mapper_flags_t  mapper_flags,
	output logic                           loader_busy,
	output logic                           loader_done,
	output logic                           loader_error,
	output logic                           cheat_valid,
	output nes_loader_pkg::cheat_code_t    cheat_code,
	output nes_loader_pkg::palette_write_t palette_out
);

	nes_loader_pkg::host_byte_t rom_byte;
	nes_loader_pkg::host_byte_t cheat_byte;
	nes_loader_pkg::host_byte_t pal_byte;
	logic       rom_restart;
	logic       download_active;
	logic       header_ok;
	logic       has_trainer;
	logic [7:0] prg_pages;
	logic [7:0] chr_pages;
	logic       hdr_write;
	logic [3:0] hdr_index;

	download_dispatch u_dispatch (
		.clk             (clk),
		.reset_nes       (reset_nes),
		.download        (download),
		.download_index  (download_index),
		.host_in         (host_in),
		.rom_restart     (rom_restart),
		.rom_byte        (rom_byte),
		.cheat_byte      (cheat_byte),
		.pal_byte        (pal_byte),
		.download_active (download_active)
	);

	rom_loader_fsm u_rom_fsm (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.rom_restart  (rom_restart),
		.rom_byte     (rom_byte),
		.header_ok    (header_ok),
		.has_trainer  (has_trainer),
		.prg_pages    (prg_pages),
		.chr_pages    (chr_pages),
		.hdr_write    (hdr_write),
		.hdr_index    (hdr_index),
		.mem_out      (mem_out),
		.loader_busy  (loader_busy),
		.loader_done  (loader_done),
		.loader_error (loader_error)
	);

	ines_header_decoder u_header (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.invert_mirroring (invert_mirroring),
		.hdr_write        (hdr_write),
		.hdr_index        (hdr_index),
		.hdr_data         (rom_byte.data),
		.load_done        (loader_done),
		.header_ok        (header_ok),
		.has_trainer      (has_trainer),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.mapper_flags     (mapper_flags)
	);

	cheat_code_assembler u_cheat (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.cheat_byte  (cheat_byte),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	palette_loader u_palette (
		.clk             (clk),
		.reset_nes       (reset_nes),
		.download_active (download_active),
		.pal_byte        (pal_byte),
		.palette_out     (palette_out)
	);

endmodule

// File: palette_loader.sv
// Palette loader
// Packs 8-bit RGB triples into 15-bit colours with a running index
`timescale 1ns/1ns
`include "nes_loader_consts.svh"

module palette_loader (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           download_active,
	input  nes_loader_pkg::host_byte_t     pal_byte,
	output nes_loader_pkg::palette_write_t palette_out
);

	logic [1:0] phase; // 0 red, 1 green, 2 blue
	logic [5:0] index;
	logic       take;

	assign take = pal_byte.strobe &&
		(pal_byte.addr < `HOST_ADDR_W'(`PALETTE_FILE_BYTES));

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			phase       <= 2'd0;
			index       <= 6'd0;
			palette_out <= '0;
		end else begin
			palette_out.write <= 1'b0;
			if (!download_active) begin
				phase <= 2'd0;
				index <= 6'd0;
			end else if (take) begin
				case (phase)
					2'd0: palette_out.color[4:0] <= pal_byte.data[7:3];
					2'd1: palette_out.color[9:5] <= pal_byte.data[7:3];
					default: begin
						palette_out.color[14:10] <= pal_byte.data[7:3];
						palette_out.index        <= index;
						palette_out.write        <= 1'b1;
						index                    <= index + 1'b1;
					end
				endcase
				phase <= (phase == 2'd2) ? 2'd0 : phase + 1'b1;
			end
		end
	end

endmodule

// File: cheat_code_assembler.sv
// Cheat code assembler
// Collects a 16-byte record into one code and strobes it out
`timescale 1ns/1ns
`include "nes_loader_consts.svh"

module cheat_code_assembler (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  nes_loader_pkg::host_byte_t  cheat_byte,
	output nes_loader_pkg::cheat_code_t cheat_code,
	output logic                        cheat_valid
);

	logic [3:0] nib;
	logic [4:0] lsb; // Bit offset inside the field

	assign nib = cheat_byte.addr[3:0];
	assign lsb = {nib[1:0], 3'b000};

	// First byte of each field is least significant
	always_ff @(posedge clk) begin
		if (cheat_byte.strobe) begin
			case (nib[3:2])
				2'd0: cheat_code.flags[lsb +: 8]   <= cheat_byte.data;
				2'd1: cheat_code.address[lsb +: 8] <= cheat_byte.data;
				2'd2: cheat_code.compare[lsb +: 8] <= cheat_byte.data;
				default: cheat_code.replace[lsb +: 8] <= cheat_byte.data;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= cheat_byte.strobe &&
				(nib == 4'(`CHEAT_RECORD_BYTES - 1));
	end

endmodule

// File: rom_loader_fsm.sv
// ROM loader FSM
// Sequences iNES header, PRG and CHR bodies into cartridge memory
// and reports busy, done and error
`timescale 1ns/1ns
`include "nes_loader_consts.svh"

module rom_loader_fsm (
	input  logic                       clk,
	input  logic                       reset_nes,
	input  logic                       rom_restart,
	input  nes_loader_pkg::host_byte_t rom_byte,
	input  logic                       header_ok,
	input  logic                       has_trainer,
	input  logic [7:0]                 prg_pages,
	input  logic [7:0]                 chr_pages,
	output logic                       hdr_write,
	output logic [3:0]                 hdr_index,
	output nes_loader_pkg::mem_write_t mem_out,
	output logic                       loader_busy,
	output logic                       loader_done,
	output logic                       loader_error
);

	typedef enum logic [2:0] {
		S_HEADER,
		S_PRG,
		S_CHR,
		S_ERROR,
		S_DONE
	} state_e;

	state_e                 state;
	logic [3:0]             hdr_cnt;
	logic [`MEM_ADDR_W-1:0] addr;
	logic [`MEM_ADDR_W-1:0] remaining; // Body bytes still to come

	assign hdr_write = rom_byte.strobe && (state == S_HEADER);
	assign hdr_index = hdr_cnt;

	always_ff @(posedge clk) begin
		if (reset_nes || rom_restart) begin
			state        <= S_HEADER;
			hdr_cnt      <= 4'd0;
			addr         <= `PRG_BASE_ADDR;
			remaining    <= '0;
			mem_out      <= '0;
			loader_busy  <= 1'b0;
			loader_done  <= 1'b0;
			loader_error <= 1'b0;
		end else begin
			mem_out.write <= 1'b0;
			case (state)
				//////////////////////////////
				// Header bytes also land in memory
				S_HEADER: begin
					if (rom_byte.strobe) begin
						mem_out.write <= 1'b1;
						mem_out.addr  <= addr;
						mem_out.data  <= rom_byte.data;
						addr          <= addr + 1'b1;
						hdr_cnt       <= hdr_cnt + 1'b1;
						if (hdr_cnt == 4'(`INES_HEADER_BYTES - 1)) begin
							// Magic and trainer bytes are already stored
							loader_busy <= 1'b1;
							if (header_ok && !has_trainer) begin
								state     <= S_PRG;
								addr      <= `PRG_BASE_ADDR;
								remaining <= `MEM_ADDR_W'(prg_pages) *
									`MEM_ADDR_W'(`PRG_PAGE_BYTES);
							end else begin
								state <= S_ERROR;
							end
						end
					end
				end

				//////////////////////////////
				S_PRG, S_CHR: begin
					if (remaining != '0) begin
						if (rom_byte.strobe) begin
							mem_out.write <= 1'b1;
							mem_out.addr  <= addr;
							mem_out.data  <= rom_byte.data;
							addr          <= addr + 1'b1;
							remaining     <= remaining - 1'b1;
						end
					end else if (state == S_PRG && chr_pages != 8'd0) begin
						state     <= S_CHR;
						addr      <= `CHR_BASE_ADDR;
						remaining <= `MEM_ADDR_W'(chr_pages) *
							`MEM_ADDR_W'(`CHR_PAGE_BYTES);
					end else begin
						state       <= S_DONE; // No CHR ROM lands here too
						loader_done <= 1'b1;
						loader_busy <= 1'b0;
					end
				end

				S_ERROR: begin
					state        <= S_DONE;
					loader_done  <= 1'b1;
					loader_error <= 1'b1;
					loader_busy  <= 1'b0;
				end

				default: ; // Hold until the next restart
			endcase
		end
	end

endmodule

// File: ines_header_decoder.sv
// iNES header decoder
// Stores the 16 header bytes and derives sizes, mapper and flags word
`timescale 1ns/1ns
`include "nes_loader_consts.svh"

module ines_header_decoder (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        invert_mirroring,
	input  logic                        hdr_write,
	input  logic [3:0]                  hdr_index,
	input  logic [7:0]                  hdr_data,
	input  logic                        load_done,
	output logic                        header_ok,
	output logic                        has_trainer,
	output logic [7:0]                  prg_pages,
	output logic [7:0]                  chr_pages,
	output nes_loader_pkg::mapper_flags_t mapper_flags
);

	nes_loader_pkg::ines_header_u  hdr;
	nes_loader_pkg::mapper_flags_t flags_comb;
	nes_loader_pkg::mapper_flags_t flags_q;
	logic is_nes20;
	logic is_dirty;

	// Ceiling log2 of a page count, capped at 7
	function automatic logic [2:0] size_code(input logic [7:0] count);
		logic [2:0] code;
		code = 3'd0;
		for (int i = 0; i < 7; i++) begin
			if (count > (8'd1 << i))
				code = 3'(i + 1);
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (hdr_write)
			hdr.bytes[hdr_index] <= hdr_data;
	end

	assign header_ok = (hdr.fields.magic[0] == `INES_MAGIC0) &&
		(hdr.fields.magic[1] == `INES_MAGIC1) &&
		(hdr.fields.magic[2] == `INES_MAGIC2) &&
		(hdr.fields.magic[3] == `INES_MAGIC3);
	assign has_trainer = hdr.fields.flags6[2];
	assign prg_pages   = hdr.fields.prg_pages;
	assign chr_pages   = hdr.fields.chr_pages;

	assign is_nes20 = (hdr.fields.flags7[3:2] == 2'b10);
	// Old dumpers left junk in the tail of 1.0 headers
	assign is_dirty = !is_nes20 && ((hdr.fields.byte9[7:1] != 7'd0) ||
		(hdr.fields.byte10 != 8'd0) || (hdr.fields.byte11 != 8'd0) ||
		(hdr.fields.byte12 != 8'd0) || (hdr.fields.byte13 != 8'd0) ||
		(hdr.fields.byte14 != 8'd0) || (hdr.fields.byte15 != 8'd0));

	always_comb begin
		flags_comb               = '0;
		flags_comb.piano         = is_nes20 && (hdr.fields.byte15[5:0] == 6'h19);
		flags_comb.prg_ram_shift = is_nes20 ? hdr.fields.byte10[3:0] : 4'h0;
		flags_comb.has_saves     = hdr.fields.flags6[1];
		flags_comb.submapper     = is_nes20 ? hdr.fields.byte8 : 8'h00;
		flags_comb.four_screen   = hdr.fields.flags6[3];
		flags_comb.has_chr_ram   = (hdr.fields.chr_pages == 8'd0);
		flags_comb.mirroring     = hdr.fields.flags6[0] ^ invert_mirroring;
		flags_comb.chr_size      = size_code(hdr.fields.chr_pages);
		flags_comb.prg_size      = size_code(hdr.fields.prg_pages);
		flags_comb.mapper[7:4]   = is_dirty ? 4'h0 : hdr.fields.flags7[7:4];
		flags_comb.mapper[3:0]   = hdr.fields.flags6[7:4];
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			flags_q <= '0;
		else if (load_done)
			flags_q <= flags_comb;
	end

	// New word shows from the first cycle of done
	assign mapper_flags = load_done ? flags_comb : flags_q;

endmodule

// File: download_dispatch.sv
// Download dispatch
// Latches the file kind when a download starts and steers host bytes
// to the ROM, cheat or palette consumer through one register stage
`timescale 1ns/1ns

module download_dispatch (
	input  logic                     clk,
	input  logic                     reset_nes,
	input  logic                     download,
	input  logic [7:0]               download_index,
	input  nes_loader_pkg::host_byte_t host_in,
	output logic                     rom_restart,
	output nes_loader_pkg::host_byte_t rom_byte,
	output nes_loader_pkg::host_byte_t cheat_byte,
	output nes_loader_pkg::host_byte_t pal_byte,
	output logic                     download_active
);

	logic download_q;
	logic start;
	nes_loader_pkg::file_kind_e idx_kind;
	nes_loader_pkg::file_kind_e kind_q;
	nes_loader_pkg::file_kind_e cur_kind;

	// File index decode
	always_comb begin
		idx_kind = nes_loader_pkg::KIND_NONE;
		if (download_index[5:0] == 6'd0) begin
			if (download_index[7:6] == 2'b01)
				idx_kind = nes_loader_pkg::KIND_ROM;
		end else if (&download_index) begin
			idx_kind = nes_loader_pkg::KIND_CHEAT;
		end else if (download_index[1:0] == 2'b01) begin
			if (download_index[7:6] == 2'b00)
				idx_kind = nes_loader_pkg::KIND_ROM;
		end else if (download_index[1:0] == 2'b11) begin
			idx_kind = nes_loader_pkg::KIND_PALETTE;
		end
	end

	assign start           = download & ~download_q;
	assign cur_kind        = start ? idx_kind : kind_q; // Kind valid on the first cycle too
	assign rom_restart     = start && (idx_kind == nes_loader_pkg::KIND_ROM);
	assign download_active = download_q;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			download_q <= 1'b0;
			kind_q     <= nes_loader_pkg::KIND_NONE;
			rom_byte   <= '0;
			cheat_byte <= '0;
			pal_byte   <= '0;
		end else begin
			download_q <= download;
			if (start)
				kind_q <= idx_kind;

			// Strobe goes only to the latched kind
			rom_byte   <= host_in;
			cheat_byte <= host_in;
			pal_byte   <= host_in;
			rom_byte.strobe   <= host_in.strobe && download &&
				(cur_kind == nes_loader_pkg::KIND_ROM);
			cheat_byte.strobe <= host_in.strobe && download &&
				(cur_kind == nes_loader_pkg::KIND_CHEAT);
			pal_byte.strobe   <= host_in.strobe && download &&
				(cur_kind == nes_loader_pkg::KIND_PALETTE);
		end
	end

endmodule

// File: nes_loader_pkg.sv
// Shared types of the NES cartridge download front end
`include "nes_loader_consts.svh"

package nes_loader_pkg;

	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_ROM,
		KIND_CHEAT,
		KIND_PALETTE
	} file_kind_e;

	// One byte from the host file loader
	typedef struct packed {
		logic                    strobe;
		logic [`HOST_ADDR_W-1:0] addr;
		logic [7:0]              data;
	} host_byte_t;

	// One write into cartridge memory
	typedef struct packed {
		logic                   write;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} mem_write_t;

	// Header bytes in file order, byte 0 on top
	typedef struct packed {
		logic [0:3][7:0] magic;
		logic [7:0]      prg_pages;
		logic [7:0]      chr_pages;
		logic [7:0]      flags6;
		logic [7:0]      flags7;
		logic [7:0]      byte8;
		logic [7:0]      byte9;
		logic [7:0]      byte10;
		logic [7:0]      byte11;
		logic [7:0]      byte12;
		logic [7:0]      byte13;
		logic [7:0]      byte14;
		logic [7:0]      byte15;
	} ines_fields_t;

	typedef union packed {
		logic [0:`INES_HEADER_BYTES-1][7:0] bytes; // Write view
		ines_fields_t                       fields; // Decode view
	} ines_header_u;

	typedef struct packed {
		logic       spare;
		logic       piano;
		logic [3:0] prg_ram_shift;
		logic       has_saves;
		logic [7:0] submapper;
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic        write;
		logic [5:0]  index;
		logic [14:0] color;
	} palette_write_t;

endpackage

// File: nes_loader_consts.svh
// NES cartridge loader constants
// iNES magic, page sizes, memory map and record lengths
`ifndef NES_LOADER_CONSTS_SVH
`define NES_LOADER_CONSTS_SVH

// "NES" followed by MS-DOS EOF
`define INES_MAGIC0 8'h4E
`define INES_MAGIC1 8'h45
`define INES_MAGIC2 8'h53
`define INES_MAGIC3 8'h1A

`define INES_HEADER_BYTES 16

// Page sizes in bytes
`define PRG_PAGE_BYTES 16384
`define CHR_PAGE_BYTES 8192

// Cartridge memory map
`define PRG_BASE_ADDR 22'h000000
`define CHR_BASE_ADDR 22'h200000

`define CHEAT_RECORD_BYTES 16
`define PALETTE_FILE_BYTES 192 // 64 RGB triples

// Bus widths
`define MEM_ADDR_W  22
`define HOST_ADDR_W 25

`endif
